/* build.f */
source/char_net_pkg.sv
source/weight_bus_if.sv
source/ctrl_regs.sv
source/seq_ctrl.sv
source/stream_in.sv
source/emb_layer.sv
source/mix_layer.sv
source/dense_layer.sv
source/comp_layer.sv
source/char_net_top.sv
tests/char_net_tb.sv

/* Makefile */
# Verilator flow for the character-prediction engine

TOP := char_net_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/char_net_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module char_net_tb;

  // one window through every stage, plus a few cycles of sequencer overhead
  localparam int WINDOW_CYCLES = (char_net_pkg::N_CTX + 1) * 2
                               + char_net_pkg::IN_DIM * char_net_pkg::HID_DIM + 1
                               + char_net_pkg::HID_DIM * char_net_pkg::CHAR_NUM + 1
                               + char_net_pkg::CHAR_NUM + 1 + 6;
  localparam int RESULT_LIMIT  = 2 * WINDOW_CYCLES;
  localparam int WATCHDOG      = 200 * WINDOW_CYCLES * 2;

  logic                    clk;
  logic                    rst_n;
  logic                    reg_wr;
  logic                    reg_rd;
  char_net_pkg::reg_addr_t reg_addr;
  char_net_pkg::reg_data_t reg_wdata;
  char_net_pkg::reg_data_t reg_rdata;
  logic                    in_valid;
  char_net_pkg::char_t     in_char;
  logic                    out_valid;
  char_net_pkg::char_t     out_char;
  char_net_pkg::acc_t      out_score;

  // reference copy of the weights
  int emb_w   [char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM];
  int mix_w   [char_net_pkg::HID_DIM * char_net_pkg::IN_DIM];
  int dense_w [char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM];

  int expected_count;
  int last_char;

  char_net_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .in_valid  (in_valid),
    .in_char   (in_char),
    .out_valid (out_valid),
    .out_char  (out_char),
    .out_score (out_score)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    stop_with_error("watchdog expired before the tests finished");
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input int got, input int expected);
    assert (got == expected)
      else stop_with_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
  endtask

  // --------------------
  // register port
  task automatic reg_write(input char_net_pkg::reg_addr_t addr,
                           input char_net_pkg::reg_data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr    = 1'b0;
  endtask

  task automatic reg_read_check(input char_net_pkg::reg_addr_t addr,
                                input char_net_pkg::reg_data_t expected);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_rd   = 1'b0;
    check_equal($sformatf("reg_rdata@%h", addr), int'(reg_rdata), int'(expected));
  endtask

  task automatic load_weights();
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM; n++) begin
      reg_write(char_net_pkg::EMB_BASE + 8'(n), 8'(emb_w[n]));
    end
    for (int n = 0; n < char_net_pkg::HID_DIM * char_net_pkg::IN_DIM; n++) begin
      reg_write(char_net_pkg::MIX_BASE + 8'(n), 8'(mix_w[n]));
    end
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM; n++) begin
      reg_write(char_net_pkg::DENSE_BASE + 8'(n), 8'(dense_w[n]));
    end
  endtask

  task automatic write_dense_row(input int k, input int val);
    for (int j = 0; j < char_net_pkg::HID_DIM; j++) begin
      dense_w[k * char_net_pkg::HID_DIM + j] = val;
      reg_write(char_net_pkg::DENSE_BASE + 8'(k * char_net_pkg::HID_DIM + j), 8'(val));
    end
  endtask

  // --------------------
  // stream side
  task automatic send_window(input char_net_pkg::char_t c0, input char_net_pkg::char_t c1);
    in_valid = 1'b1;
    in_char  = c0;
    @(negedge clk);
    in_char  = c1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // returns once the engine is back in idle
  task automatic wait_result(output int got_c, output int got_s);
    int cycles;
    cycles = 0;
    while (out_valid !== 1'b1 && cycles < RESULT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (out_valid === 1'b1)
      else stop_with_error($sformatf("no out_valid within %0d cycles", RESULT_LIMIT));
    got_c = int'(out_char);
    got_s = int'(out_score);
    repeat (2) @(negedge clk);
  endtask

  // embedding, mix with shift and clamp, dense, first maximum
  task automatic predict(input char_net_pkg::char_t c0, input char_net_pkg::char_t c1,
                         output int best_c, output int best_s);
    int x [char_net_pkg::IN_DIM];
    int h [char_net_pkg::HID_DIM];
    int sum;
    for (int k = 0; k < char_net_pkg::EMB_DIM; k++) begin
      x[k] = emb_w[int'(c0) * char_net_pkg::EMB_DIM + k];
      x[char_net_pkg::EMB_DIM + k] = emb_w[int'(c1) * char_net_pkg::EMB_DIM + k];
    end
    for (int j = 0; j < char_net_pkg::HID_DIM; j++) begin
      sum = 0;
      for (int i = 0; i < char_net_pkg::IN_DIM; i++) begin
        sum = sum + mix_w[j * char_net_pkg::IN_DIM + i] * x[i];
      end
      sum = sum >>> char_net_pkg::MIX_SHIFT;
      if (sum > char_net_pkg::ACT_MAX) begin
        sum = char_net_pkg::ACT_MAX;
      end else if (sum < -char_net_pkg::ACT_MAX) begin
        sum = -char_net_pkg::ACT_MAX;
      end
      h[j] = sum;
    end
    best_c = 0;
    best_s = 0;
    for (int k = 0; k < char_net_pkg::CHAR_NUM; k++) begin
      sum = 0;
      for (int j = 0; j < char_net_pkg::HID_DIM; j++) begin
        sum = sum + dense_w[k * char_net_pkg::HID_DIM + j] * h[j];
      end
      if (k == 0 || sum > best_s) begin
        best_c = k;
        best_s = sum;
      end
    end
  endtask

  task automatic run_window_check(input char_net_pkg::char_t c0,
                                  input char_net_pkg::char_t c1);
    int exp_c;
    int exp_s;
    int got_c;
    int got_s;
    predict(c0, c1, exp_c, exp_s);
    reg_write(char_net_pkg::ADDR_CTRL, 8'h01);
    send_window(c0, c1);
    wait_result(got_c, got_s);
    expected_count = expected_count + 1;
    last_char = got_c;
    check_equal("out_char", got_c, exp_c);
    check_equal("out_score", got_s, exp_s);
  endtask

  // --------------------
  // directed tests
  task automatic after_reset();
    reg_read_check(char_net_pkg::ADDR_STATUS, 8'h00);
    reg_read_check(char_net_pkg::ADDR_COUNT, 8'h00);
    for (int n = 0; n < 20; n++) begin
      assert (out_valid === 1'b0)
        else stop_with_error("out_valid rose while idle after reset");
      @(negedge clk);
    end
  endtask

  task automatic known_weights();
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM; n++) begin
      emb_w[n] = n - 8;
    end
    // h equals x
    for (int j = 0; j < char_net_pkg::HID_DIM; j++) begin
      for (int i = 0; i < char_net_pkg::IN_DIM; i++) begin
        mix_w[j * char_net_pkg::IN_DIM + i] = (i == j) ? 16 : 0;
      end
    end
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM; n++) begin
      dense_w[n] = (n / char_net_pkg::HID_DIM == 11) ? 3 : 1;
    end
    load_weights();
    run_window_check(4'd12, 4'd7);
    check_equal("out_char", last_char, 11);
    reg_read_check(char_net_pkg::ADDR_STATUS, 8'h02);
    reg_read_check(char_net_pkg::ADDR_COUNT, 8'h01);
  endtask

  task automatic random_windows();
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM; n++) begin
      emb_w[n] = int'($urandom_range(0, 63)) - 32;
    end
    for (int n = 0; n < char_net_pkg::HID_DIM * char_net_pkg::IN_DIM; n++) begin
      mix_w[n] = int'($urandom_range(0, 127)) - 64;
    end
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM; n++) begin
      dense_w[n] = int'($urandom_range(0, 255)) - 128;
    end
    load_weights();
    for (int w = 0; w < 30; w++) begin
      run_window_check(char_net_pkg::char_t'($urandom_range(0, 15)),
                       char_net_pkg::char_t'($urandom_range(0, 15)));
    end
    reg_read_check(char_net_pkg::ADDR_COUNT, 8'(expected_count % 256));
  endtask

  task automatic saturation();
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM; n++) begin
      emb_w[n] = 100;
    end
    // rows 0 and 3 clip high, row 1 clips low, row 2 stays just inside
    for (int i = 0; i < char_net_pkg::IN_DIM; i++) begin
      mix_w[i] = 100;
      mix_w[char_net_pkg::IN_DIM + i] = -100;
      mix_w[2 * char_net_pkg::IN_DIM + i] = 5;
      mix_w[3 * char_net_pkg::IN_DIM + i] = 20;
    end
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM; n++) begin
      dense_w[n] = int'($urandom_range(0, 255)) - 128;
    end
    load_weights();
    run_window_check(4'd3, 4'd14);
    run_window_check(4'd15, 4'd0);
  endtask

  task automatic tie_break();
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM; n++) begin
      emb_w[n] = 16;
    end
    for (int j = 0; j < char_net_pkg::HID_DIM; j++) begin
      for (int i = 0; i < char_net_pkg::IN_DIM; i++) begin
        mix_w[j * char_net_pkg::IN_DIM + i] = (i == j) ? 16 : 0;
      end
    end
    for (int n = 0; n < char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM; n++) begin
      dense_w[n] = 3;
    end
    load_weights();
    run_window_check(4'd2, 4'd9);
    check_equal("out_char", last_char, 0);
    write_dense_row(5, 10);
    write_dense_row(9, 10);
    run_window_check(4'd6, 4'd1);
    check_equal("out_char", last_char, 5);
  endtask

  task automatic ignored_traffic();
    int exp_c;
    int exp_s;
    int got_c;
    int got_s;
    // stray characters with the engine idle
    for (int n = 0; n < 3; n++) begin
      in_valid = 1'b1;
      in_char  = char_net_pkg::char_t'(n + 3);
      @(negedge clk);
      in_valid = 1'b0;
      @(negedge clk);
    end
    predict(4'd8, 4'd13, exp_c, exp_s);
    reg_write(char_net_pkg::ADDR_CTRL, 8'h01);
    send_window(4'd8, 4'd13);
    // engine busy here, both writes must be dropped
    reg_write(char_net_pkg::DENSE_BASE + 8'(9 * char_net_pkg::HID_DIM), 8'd127);
    reg_write(char_net_pkg::ADDR_CTRL, 8'h01);
    wait_result(got_c, got_s);
    expected_count = expected_count + 1;
    check_equal("out_char", got_c, exp_c);
    check_equal("out_score", got_s, exp_s);
    for (int n = 0; n < 40; n++) begin
      assert (out_valid === 1'b0)
        else stop_with_error("a second result appeared after a start issued while busy");
      @(negedge clk);
    end
    // a queued second start would leave the engine busy in F_RECV
    reg_read_check(char_net_pkg::ADDR_STATUS, 8'h02);
    reg_read_check(char_net_pkg::ADDR_COUNT, 8'(expected_count % 256));
    run_window_check(4'd8, 4'd13);
  endtask

  // --------------------
  // main sequence
  initial begin
    void'($urandom(32'h27c3deea));
    expected_count = 0;
    last_char      = 0;
    rst_n          = 1'b0;
    reg_wr         = 1'b0;
    reg_rd         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    in_valid       = 1'b0;
    in_char        = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    after_reset();
    known_weights();
    random_windows();
    saturation();
    tie_break();
    ignored_traffic();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* source/char_net_top.sv */
`timescale 1ns/1ns
`default_nettype none

module char_net_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          reg_wr,
  input  wire                          reg_rd,
  input  wire char_net_pkg::reg_addr_t reg_addr,
  input  wire char_net_pkg::reg_data_t reg_wdata,
  output wire char_net_pkg::reg_data_t reg_rdata,
  input  wire                          in_valid,
  input  wire char_net_pkg::char_t     in_char,
  output wire                          out_valid,
  output wire char_net_pkg::char_t     out_char,
  output wire char_net_pkg::acc_t      out_score
);

  // --------------------
  // sequencer handshakes
  logic busy;
  logic start;
  logic recv_en;
  logic recv_done;
  logic emb_run;
  logic emb_done;
  logic mix_run;
  logic mix_done;
  logic dense_run;
  logic dense_done;
  logic comp_run;
  logic comp_done;

  // layer data
  char_net_pkg::char_t   window [char_net_pkg::N_CTX];
  char_net_pkg::weight_t x      [char_net_pkg::IN_DIM];
  char_net_pkg::act_t    h      [char_net_pkg::HID_DIM];
  char_net_pkg::acc_t    score  [char_net_pkg::CHAR_NUM];

  weight_bus_if wbus ();

  ctrl_regs ctrl_regs_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .busy      (busy),
    .result    (out_valid),
    .start     (start),
    .wbus      (wbus.host)
  );

  seq_ctrl seq_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .recv_done  (recv_done),
    .emb_done   (emb_done),
    .mix_done   (mix_done),
    .dense_done (dense_done),
    .comp_done  (comp_done),
    .busy       (busy),
    .recv_en    (recv_en),
    .emb_run    (emb_run),
    .mix_run    (mix_run),
    .dense_run  (dense_run),
    .comp_run   (comp_run),
    .out_valid  (out_valid)
  );

  stream_in stream_in_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (recv_en),
    .in_valid (in_valid),
    .in_char  (in_char),
    .done     (recv_done),
    .window   (window)
  );

  emb_layer emb_layer_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wbus   (wbus.layer),
    .run    (emb_run),
    .window (window),
    .done   (emb_done),
    .x      (x)
  );

  mix_layer mix_layer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wbus  (wbus.layer),
    .run   (mix_run),
    .x     (x),
    .done  (mix_done),
    .h     (h)
  );

  dense_layer dense_layer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wbus  (wbus.layer),
    .run   (dense_run),
    .h     (h),
    .done  (dense_done),
    .score (score)
  );

  comp_layer comp_layer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (comp_run),
    .score      (score),
    .done       (comp_done),
    .best_char  (out_char),
    .best_score (out_score)
  );

endmodule

`default_nettype wire

/* source/comp_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module comp_layer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     run,
  input  wire char_net_pkg::acc_t score [char_net_pkg::CHAR_NUM],
  output logic                    done,
  output char_net_pkg::char_t     best_char,
  output char_net_pkg::acc_t      best_score
);

  logic                active;
  char_net_pkg::char_t idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      idx    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (run) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (active) begin
        idx <= idx + 1'b1;
        if (int'(idx) == char_net_pkg::CHAR_NUM - 1) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // strictly greater only, ties keep the lower index
  always_ff @(posedge clk) begin
    if (active && (idx == '0 || score[idx] > best_score)) begin
      best_char  <= idx;
      best_score <= score[idx];
    end
  end

endmodule

`default_nettype wire

/* source/dense_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module dense_layer (
  input  wire                     clk,
  input  wire                     rst_n,
  weight_bus_if.layer             wbus,
  input  wire                     run,
  input  wire char_net_pkg::act_t h [char_net_pkg::HID_DIM],
  output logic                    done,
  output char_net_pkg::acc_t      score [char_net_pkg::CHAR_NUM]
);

  char_net_pkg::weight_t dense_mem [char_net_pkg::CHAR_NUM * char_net_pkg::HID_DIM];
  logic                                     active;
  logic [$clog2(char_net_pkg::HID_DIM)-1:0] j;
  char_net_pkg::char_t                      k;
  char_net_pkg::acc_t                       acc;
  char_net_pkg::acc_t                       prod;
  char_net_pkg::acc_t                       sum;

  always_ff @(posedge clk) begin
    if (wbus.wr && wbus.sel == char_net_pkg::SEL_DENSE) begin
      dense_mem[wbus.addr] <= wbus.data;
    end
  end

  assign prod = char_net_pkg::acc_t'(dense_mem[int'(k) * char_net_pkg::HID_DIM + int'(j)])
              * char_net_pkg::acc_t'(h[j]);
  assign sum  = (j == '0) ? prod : acc + prod;

  // --------------------
  // row k over hidden index j
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      j      <= '0;
      k      <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (run) begin
        active <= 1'b1;
        j      <= '0;
        k      <= '0;
      end else if (active) begin
        if (int'(j) == char_net_pkg::HID_DIM - 1) begin
          j <= '0;
          k <= k + 1'b1;
          if (int'(k) == char_net_pkg::CHAR_NUM - 1) begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end else begin
          j <= j + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      acc <= sum;
      if (int'(j) == char_net_pkg::HID_DIM - 1) begin
        score[k] <= sum;
      end
    end
  end

endmodule

`default_nettype wire

/* source/mix_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module mix_layer (
  input  wire                        clk,
  input  wire                        rst_n,
  weight_bus_if.layer                wbus,
  input  wire                        run,
  input  wire char_net_pkg::weight_t x [char_net_pkg::IN_DIM],
  output logic                       done,
  output char_net_pkg::act_t         h [char_net_pkg::HID_DIM]
);

  char_net_pkg::weight_t mix_mem [char_net_pkg::HID_DIM * char_net_pkg::IN_DIM];
  logic                                     active;
  logic [$clog2(char_net_pkg::IN_DIM)-1:0]  i;
  logic [$clog2(char_net_pkg::HID_DIM)-1:0] j;
  char_net_pkg::acc_t                       acc;
  char_net_pkg::acc_t                       prod;
  char_net_pkg::acc_t                       sum;

  // shift then hard-tanh
  function automatic char_net_pkg::act_t clamp(input char_net_pkg::acc_t v);
    char_net_pkg::acc_t s;
    s = v >>> char_net_pkg::MIX_SHIFT;
    if (s > char_net_pkg::ACT_MAX) begin
      return char_net_pkg::act_t'(char_net_pkg::ACT_MAX);
    end
    if (s < -char_net_pkg::ACT_MAX) begin
      return char_net_pkg::act_t'(-char_net_pkg::ACT_MAX);
    end
    return char_net_pkg::act_t'(s);
  endfunction

  always_ff @(posedge clk) begin
    if (wbus.wr && wbus.sel == char_net_pkg::SEL_MIX) begin
      mix_mem[wbus.addr[3:0]] <= wbus.data;
    end
  end

  // single multiplier, i runs fastest
  assign prod = char_net_pkg::acc_t'(mix_mem[int'(j) * char_net_pkg::IN_DIM + int'(i)])
              * char_net_pkg::acc_t'(x[i]);
  assign sum  = (i == '0) ? prod : acc + prod;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      i      <= '0;
      j      <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (run) begin
        active <= 1'b1;
        i      <= '0;
        j      <= '0;
      end else if (active) begin
        if (int'(i) == char_net_pkg::IN_DIM - 1) begin
          i <= '0;
          j <= j + 1'b1;
          if (int'(j) == char_net_pkg::HID_DIM - 1) begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end else begin
          i <= i + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      acc <= sum;
      if (int'(i) == char_net_pkg::IN_DIM - 1) begin
        h[j] <= clamp(sum);
      end
    end
  end

  // loop reaches the last weight exactly one cycle before done
  loop_bounds: assert property (@(posedge clk) disable iff (!rst_n)
    run |-> ##(char_net_pkg::IN_DIM * char_net_pkg::HID_DIM)
      (active && int'(i) == char_net_pkg::IN_DIM - 1 && int'(j) == char_net_pkg::HID_DIM - 1)
      ##1 done);

endmodule

`default_nettype wire

/* source/emb_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module emb_layer (
  input  wire                      clk,
  input  wire                      rst_n,
  weight_bus_if.layer              wbus,
  input  wire                      run,
  input  wire char_net_pkg::char_t window [char_net_pkg::N_CTX],
  output logic                     done,
  output char_net_pkg::weight_t    x [char_net_pkg::IN_DIM]
);

  char_net_pkg::weight_t emb_mem [char_net_pkg::CHAR_NUM * char_net_pkg::EMB_DIM];
  logic                                   active;
  logic [$clog2(char_net_pkg::N_CTX)-1:0] pos;

  always_ff @(posedge clk) begin
    if (wbus.wr && wbus.sel == char_net_pkg::SEL_EMB) begin
      emb_mem[wbus.addr[4:0]] <= wbus.data;
    end
  end

  // one context character per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      pos    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (run) begin
        active <= 1'b1;
        pos    <= '0;
      end else if (active) begin
        pos <= pos + 1'b1;
        if (int'(pos) == char_net_pkg::N_CTX - 1) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      for (int k = 0; k < char_net_pkg::EMB_DIM; k++) begin
        x[int'(pos) * char_net_pkg::EMB_DIM + k] <=
          emb_mem[int'(window[pos]) * char_net_pkg::EMB_DIM + k];
      end
    end
  end

endmodule

`default_nettype wire

/* source/stream_in.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_in (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      en,
  input  wire                      in_valid,
  input  wire char_net_pkg::char_t in_char,
  output logic                     done,
  output char_net_pkg::char_t      window [char_net_pkg::N_CTX]
);

  logic [$clog2(char_net_pkg::N_CTX)-1:0] cnt;
  logic                                   take;

  // nothing is taken in the cycle that reports a full window
  assign take = en && in_valid && !done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!en) begin
        cnt <= '0;
      end else if (take) begin
        if (int'(cnt) == char_net_pkg::N_CTX - 1) begin
          cnt  <= '0;
          done <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // oldest character ends up in window[0]
  always_ff @(posedge clk) begin
    if (take) begin
      for (int n = 0; n < char_net_pkg::N_CTX - 1; n++) begin
        window[n] <= window[n+1];
      end
      window[char_net_pkg::N_CTX-1] <= in_char;
    end
  end

endmodule

`default_nettype wire

/* source/seq_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module seq_ctrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  start,
  input  wire  recv_done,
  input  wire  emb_done,
  input  wire  mix_done,
  input  wire  dense_done,
  input  wire  comp_done,
  output logic busy,
  output logic recv_en,
  output logic emb_run,
  output logic mix_run,
  output logic dense_run,
  output logic comp_run,
  output logic out_valid
);

  char_net_pkg::fwd_state_t state;

  // each run strobe is raised in the first cycle of its stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= char_net_pkg::F_IDLE;
      emb_run   <= 1'b0;
      mix_run   <= 1'b0;
      dense_run <= 1'b0;
      comp_run  <= 1'b0;
    end else begin
      emb_run   <= 1'b0;
      mix_run   <= 1'b0;
      dense_run <= 1'b0;
      comp_run  <= 1'b0;
      case (state)
        char_net_pkg::F_IDLE: begin
          if (start) begin
            state <= char_net_pkg::F_RECV;
          end
        end
        char_net_pkg::F_RECV: begin
          if (recv_done) begin
            state   <= char_net_pkg::F_EMB;
            emb_run <= 1'b1;
          end
        end
        char_net_pkg::F_EMB: begin
          if (emb_done) begin
            state   <= char_net_pkg::F_MIX;
            mix_run <= 1'b1;
          end
        end
        char_net_pkg::F_MIX: begin
          if (mix_done) begin
            state     <= char_net_pkg::F_DENS;
            dense_run <= 1'b1;
          end
        end
        char_net_pkg::F_DENS: begin
          if (dense_done) begin
            state    <= char_net_pkg::F_COMP;
            comp_run <= 1'b1;
          end
        end
        char_net_pkg::F_COMP: begin
          if (comp_done) begin
            state <= char_net_pkg::F_SEND;
          end
        end
        char_net_pkg::F_SEND: state <= char_net_pkg::F_FIN;
        default:              state <= char_net_pkg::F_IDLE;
      endcase
    end
  end

  assign busy      = (state != char_net_pkg::F_IDLE);
  assign recv_en   = (state == char_net_pkg::F_RECV);
  assign out_valid = (state == char_net_pkg::F_SEND);

  // a layer finishing outside its own stage means the run/done pairing broke
  stage_done: assert property (@(posedge clk) disable iff (!rst_n)
    !((recv_done  && state != char_net_pkg::F_RECV) ||
      (emb_done   && state != char_net_pkg::F_EMB)  ||
      (mix_done   && state != char_net_pkg::F_MIX)  ||
      (dense_done && state != char_net_pkg::F_DENS) ||
      (comp_done  && state != char_net_pkg::F_COMP)));

endmodule

`default_nettype wire

/* source/ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          reg_wr,
  input  wire                          reg_rd,
  input  wire char_net_pkg::reg_addr_t reg_addr,
  input  wire char_net_pkg::reg_data_t reg_wdata,
  output char_net_pkg::reg_data_t      reg_rdata,
  input  wire                          busy,
  input  wire                          result,
  output logic                         start,
  weight_bus_if.host                   wbus
);

  logic                     done_seen;
  char_net_pkg::reg_data_t  count;
  logic                     w_hit;
  char_net_pkg::layer_sel_t w_sel;
  logic [5:0]               w_off;

  // start only from idle
  assign start = reg_wr && !busy && (reg_addr == char_net_pkg::ADDR_CTRL) && reg_wdata[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_seen <= 1'b0;
      count     <= '0;
    end else begin
      if (start) begin
        done_seen <= 1'b0;
      end else if (result) begin
        done_seen <= 1'b1;
      end
      if (result) begin
        count <= count + 1'b1;
      end
    end
  end

  // read data one cycle after reg_rd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        char_net_pkg::ADDR_STATUS: reg_rdata <= {6'b0, done_seen, busy};
        char_net_pkg::ADDR_COUNT:  reg_rdata <= count;
        default:                   reg_rdata <= '0;
      endcase
    end
  end

  // --------------------
  // weight region decode
  always_comb begin
    w_hit = 1'b1;
    w_sel = char_net_pkg::SEL_EMB;
    w_off = 6'(reg_addr - char_net_pkg::EMB_BASE);
    if (reg_addr[7:6] == char_net_pkg::DENSE_BASE[7:6]) begin
      w_sel = char_net_pkg::SEL_DENSE;
      w_off = 6'(reg_addr - char_net_pkg::DENSE_BASE);
    end else if (reg_addr[7:4] == char_net_pkg::MIX_BASE[7:4]) begin
      w_sel = char_net_pkg::SEL_MIX;
      w_off = 6'(reg_addr - char_net_pkg::MIX_BASE);
    end else if (reg_addr[7:5] != char_net_pkg::EMB_BASE[7:5]) begin
      w_hit = 1'b0;
    end
  end

  // writes while busy are dropped here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbus.wr <= 1'b0;
    end else begin
      wbus.wr <= reg_wr && w_hit && !busy;
    end
  end

  always_ff @(posedge clk) begin
    wbus.sel  <= w_sel;
    wbus.addr <= w_off;
    wbus.data <= reg_wdata;
  end

  // a write accepted just before start must land before the engine leaves idle
  wr_idle: assert property (@(posedge clk) disable iff (!rst_n) wbus.wr |-> !busy);

endmodule

`default_nettype wire

/* source/weight_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

// weight writes from the register block, one entry per strobe
interface weight_bus_if;

  logic                     wr;
  char_net_pkg::layer_sel_t sel;
  logic [5:0]               addr;
  char_net_pkg::weight_t    data;

  modport host (
    output wr, sel, addr, data
  );

  modport layer (
    input wr, sel, addr, data
  );

endinterface

`default_nettype wire

/* source/char_net_pkg.sv */
`default_nettype none

package char_net_pkg;

  // --------------------
  // value types
  typedef logic        [3:0]  char_t;
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [7:0]  act_t;
  typedef logic signed [17:0] acc_t;
  typedef logic        [7:0]  reg_addr_t;
  typedef logic        [7:0]  reg_data_t;

  // --------------------
  // network sizes
  localparam int CHAR_NUM  = 16;
  localparam int N_CTX     = 2;
  localparam int EMB_DIM   = 2;
  localparam int IN_DIM    = N_CTX * EMB_DIM;
  localparam int HID_DIM   = 4;
  localparam int MIX_SHIFT = 4;
  localparam int ACT_MAX   = 127;

  // --------------------
  // register map
  localparam reg_addr_t ADDR_CTRL   = 8'h00;
  localparam reg_addr_t ADDR_STATUS = 8'h01;
  localparam reg_addr_t ADDR_COUNT  = 8'h02;
  // emb index is char*2+k, mix is j*4+i, dense is k*4+j
  localparam reg_addr_t EMB_BASE    = 8'h20;
  localparam reg_addr_t MIX_BASE    = 8'h40;
  localparam reg_addr_t DENSE_BASE  = 8'h80;

  // target memory of a weight write
  typedef enum logic [1:0] {
    SEL_EMB,
    SEL_MIX,
    SEL_DENSE
  } layer_sel_t;

  // forward pass sequence
  typedef enum logic [2:0] {
    F_IDLE,
    F_RECV,
    F_EMB,
    F_MIX,
    F_DENS,
    F_COMP,
    F_SEND,
    F_FIN
  } fwd_state_t;

endpackage

`default_nettype wire
